/* hdl/pixel_pkg.sv */
// pixel, column and window types shared by the line window datapath
package pixel_pkg;

    // RGB pixel, 8 bits per channel
    localparam int PIXEL_W = 24;

    // edge of the square window
    localparam int WIN_N = 4;

    typedef logic [PIXEL_W-1:0] pixel_t;

    // element 0 is the top row, placed in the upper bits
    typedef pixel_t [0:WIN_N-1] column_t;

    // element 0 is the left column
    typedef column_t [0:WIN_N-1] window_t;

endpackage

/* hdl/geom_pkg.sv */
// line buffer geometry: bank count, line width limit and index types
package geom_pkg;

    // one bank more than the window height, so one row can load during reads
    localparam int NUM_BANKS = 5;

    localparam int MAX_LINE_W = 1024;

    typedef logic [$clog2(MAX_LINE_W)-1:0] col_addr_t;

    typedef logic [$clog2(NUM_BANKS)-1:0] bank_idx_t;

    // number of full banks, 0 up to NUM_BANKS
    typedef logic [$clog2(NUM_BANKS+1)-1:0] line_cnt_t;

endpackage

/* hdl/line_writer.sv */
// line writer: stores incoming rows into free banks and tracks the full bank count
`timescale 1ns/100ps

module line_writer #(
    parameter int LINE_WIDTH = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  logic                line_release,
    output logic                in_ready,
    output logic                wr_en,
    output geom_pkg::bank_idx_t wr_bank,
    output geom_pkg::col_addr_t wr_addr,
    output logic                lines_ready
);

    localparam geom_pkg::col_addr_t LAST_COL = geom_pkg::col_addr_t'(LINE_WIDTH - 1);
    localparam geom_pkg::bank_idx_t LAST_BANK = geom_pkg::bank_idx_t'(geom_pkg::NUM_BANKS - 1);
    localparam geom_pkg::line_cnt_t ALL_FULL = geom_pkg::line_cnt_t'(geom_pkg::NUM_BANKS);
    // a full row set needs every bank but the one being written
    localparam geom_pkg::line_cnt_t SET_FULL = geom_pkg::line_cnt_t'(geom_pkg::NUM_BANKS - 1);

    geom_pkg::line_cnt_t full_cnt;
    logic                row_done;

    assign in_ready    = (full_cnt < ALL_FULL);
    assign lines_ready = (full_cnt >= SET_FULL);
    assign wr_en       = in_valid & in_ready;
    assign row_done    = wr_en && (wr_addr == LAST_COL);

    // write column and target bank
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_addr <= '0;
            wr_bank <= '0;
        end else if (wr_en) begin
            if (row_done) begin
                wr_addr <= '0;
                wr_bank <= (wr_bank == LAST_BANK) ? geom_pkg::bank_idx_t'(0) : wr_bank + 1'b1;
            end else begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

    // a finished row and a release in the same cycle cancel out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full_cnt <= '0;
        end else if (row_done && !line_release) begin
            full_cnt <= full_cnt + 1'b1;
        end else if (!row_done && line_release) begin
            full_cnt <= full_cnt - 1'b1;
        end
    end

endmodule

/* hdl/line_store.sv */
// line store: five row memories, one pixel write port and a rotated four-row read port
`timescale 1ns/100ps

module line_store (
    input  logic                clk,
    input  logic                wr_en,
    input  geom_pkg::bank_idx_t wr_bank,
    input  geom_pkg::col_addr_t wr_addr,
    input  pixel_pkg::pixel_t   wr_data,
    input  logic                rd_en,
    input  geom_pkg::bank_idx_t rd_base,
    input  geom_pkg::col_addr_t rd_addr,
    output pixel_pkg::column_t  rd_col
);

    pixel_pkg::pixel_t mem [geom_pkg::NUM_BANKS][geom_pkg::MAX_LINE_W];

    // bank that lies offset rows below base, wrapping over the bank ring
    function automatic geom_pkg::bank_idx_t bank_at(
        input geom_pkg::bank_idx_t base,
        input int                  offset
    );
        int sum;
        sum = int'(base) + offset;
        if (sum >= geom_pkg::NUM_BANKS) begin
            sum = sum - geom_pkg::NUM_BANKS;
        end
        return geom_pkg::bank_idx_t'(sum);
    endfunction

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_bank][wr_addr] <= wr_data;
        end
    end

    // oldest row goes to the top of the column
    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int i = 0; i < pixel_pkg::WIN_N; i++) begin
                rd_col[i] <= mem[bank_at(rd_base, i)][rd_addr];
            end
        end
    end

endmodule

/* hdl/column_reader.sv */
// column reader: scans the columns of the current row set and frees the oldest bank
`timescale 1ns/100ps

module column_reader #(
    parameter int LINE_WIDTH = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                lines_ready,
    input  logic                col_ready,
    output logic                rd_en,
    output geom_pkg::bank_idx_t rd_base,
    output geom_pkg::col_addr_t rd_addr,
    output logic                line_release,
    output logic                col_valid,
    output logic                col_first
);

    localparam geom_pkg::col_addr_t LAST_COL = geom_pkg::col_addr_t'(LINE_WIDTH - 1);
    localparam geom_pkg::bank_idx_t LAST_BANK = geom_pkg::bank_idx_t'(geom_pkg::NUM_BANKS - 1);

    logic last_col;

    assign last_col = (rd_addr == LAST_COL);

    // lines_ready still shows the old count during the release cycle, so hold off
    assign rd_en = lines_ready & ~line_release & (~col_valid | col_ready);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr      <= '0;
            line_release <= 1'b0;
        end else begin
            line_release <= rd_en & last_col;
            if (rd_en) begin
                rd_addr <= last_col ? geom_pkg::col_addr_t'(0) : rd_addr + 1'b1;
            end
        end
    end

    // rotate to the next row set together with the bank count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_base <= '0;
        end else if (line_release) begin
            rd_base <= (rd_base == LAST_BANK) ? geom_pkg::bank_idx_t'(0) : rd_base + 1'b1;
        end
    end

    // column waiting in the line store read register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_valid <= 1'b0;
            col_first <= 1'b0;
        end else if (rd_en) begin
            col_valid <= 1'b1;
            col_first <= (rd_addr == '0);
        end else if (col_ready) begin
            col_valid <= 1'b0;
        end
    end

endmodule

/* hdl/window_shift.sv */
// window shifter: builds 4x4 windows from a stream of four-pixel columns
`timescale 1ns/100ps

module window_shift (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               col_valid,
    input  logic               col_first,
    input  pixel_pkg::column_t col_data,
    input  logic               win_ready,
    output logic               col_ready,
    output logic               win_valid,
    output pixel_pkg::window_t win_data
);

    localparam int CNT_W = $clog2(pixel_pkg::WIN_N + 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(pixel_pkg::WIN_N);

    logic [CNT_W-1:0] col_cnt;
    logic             take;

    assign col_ready = ~win_valid | win_ready;
    assign take      = col_valid & col_ready;

    // columns of the current set, saturating once the window is full
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_cnt   <= '0;
            win_valid <= 1'b0;
        end else if (take) begin
            if (col_first) begin
                col_cnt   <= CNT_W'(1);
                win_valid <= 1'b0;
            end else begin
                col_cnt   <= (col_cnt == FULL_CNT) ? FULL_CNT : col_cnt + 1'b1;
                win_valid <= (col_cnt >= FULL_CNT - 1'b1);
            end
        end else if (win_ready) begin
            win_valid <= 1'b0;
        end
    end

    // new column enters at the right
    always_ff @(posedge clk) begin
        if (take) begin
            win_data <= {win_data[1:pixel_pkg::WIN_N-1], col_data};
        end
    end

endmodule

/* hdl/line_window_top.sv */
// line window top: turns a pixel stream into a stream of 4x4 windows
`timescale 1ns/100ps

module line_window_top #(
    parameter int LINE_WIDTH = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  pixel_pkg::pixel_t  in_data,
    output logic               in_ready,
    output logic               win_valid,
    output pixel_pkg::window_t win_data,
    input  logic               win_ready
);

    logic                wr_en;
    geom_pkg::bank_idx_t wr_bank;
    geom_pkg::col_addr_t wr_addr;
    logic                lines_ready;
    logic                rd_en;
    geom_pkg::bank_idx_t rd_base;
    geom_pkg::col_addr_t rd_addr;
    pixel_pkg::column_t  rd_col;
    logic                line_release;
    logic                col_valid;
    logic                col_first;
    logic                col_ready;

    line_writer #(
        .LINE_WIDTH(LINE_WIDTH)
    ) u_line_writer (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .line_release(line_release),
        .in_ready(in_ready), .wr_en(wr_en), .wr_bank(wr_bank), .wr_addr(wr_addr),
        .lines_ready(lines_ready)
    );

    line_store u_line_store (
        .clk(clk), .wr_en(wr_en), .wr_bank(wr_bank), .wr_addr(wr_addr), .wr_data(in_data),
        .rd_en(rd_en), .rd_base(rd_base), .rd_addr(rd_addr), .rd_col(rd_col)
    );

    column_reader #(
        .LINE_WIDTH(LINE_WIDTH)
    ) u_column_reader (
        .clk(clk), .rst_n(rst_n), .lines_ready(lines_ready), .col_ready(col_ready),
        .rd_en(rd_en), .rd_base(rd_base), .rd_addr(rd_addr), .line_release(line_release),
        .col_valid(col_valid), .col_first(col_first)
    );

    window_shift u_window_shift (
        .clk(clk), .rst_n(rst_n), .col_valid(col_valid), .col_first(col_first),
        .col_data(rd_col), .win_ready(win_ready), .col_ready(col_ready),
        .win_valid(win_valid), .win_data(win_data)
    );

endmodule

/* sim/line_window_sva.sv */
// assertions on the window output handshake and the input ready of the line window top
`timescale 1ns/100ps

module line_window_sva (
    input logic               clk,
    input logic               rst_n,
    input logic               in_ready,
    input logic               win_valid,
    input pixel_pkg::window_t win_data,
    input logic               win_ready
);

    // a stalled window keeps valid high and its data unchanged
    win_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
        win_valid && !win_ready |=> win_valid)
    else $error("win_valid dropped while the window was stalled");

    win_data_held: assert property (@(posedge clk) disable iff (!rst_n)
        win_valid && !win_ready |=> $stable(win_data))
    else $error("win_data changed while the window was stalled");

    win_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(win_valid))
    else $error("win_valid is unknown");

    in_ready_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(in_ready))
    else $error("in_ready is unknown");

endmodule

bind line_window_top line_window_sva u_sva (
    .clk(clk), .rst_n(rst_n), .in_ready(in_ready), .win_valid(win_valid),
    .win_data(win_data), .win_ready(win_ready)
);

/* sim/tb_line_window.sv */
// testbench for the line window top: table-driven pixel streams checked against a window model
`timescale 1ns/100ps

module tb_line_window;

    localparam int LINE_WIDTH  = 8;
    localparam int NUM_CASES   = 6;
    localparam int RST_CYCLES  = 4;
    localparam int WAIT_LIMIT  = 2000;
    localparam int HOLD_CYCLES = 100;
    localparam int SEED        = 55668;

    // image rows, input gap and output stall chance in percent, long stall flag, windows
    typedef struct packed {
        int rows;
        int gap;
        int stall;
        int hold;
        int wins;
    } case_t;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               in_valid;
    pixel_pkg::pixel_t  in_data;
    logic               in_ready;
    logic               win_valid;
    pixel_pkg::window_t win_data;
    logic               win_ready;

    case_t              cases [NUM_CASES];
    pixel_pkg::window_t exp_q [$];
    logic               hold_active;
    int                 err_value;
    int                 err_other;

    always #4 clk = ~clk;

    line_window_top #(
        .LINE_WIDTH(LINE_WIDTH)
    ) UUT (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .in_data(in_data),
        .in_ready(in_ready), .win_valid(win_valid), .win_data(win_data),
        .win_ready(win_ready)
    );

    task automatic load_table();
        cases[0] = '{4, 0, 0, 0, 5};
        cases[1] = '{10, 0, 0, 0, 35};
        cases[2] = '{10, 0, 40, 0, 35};
        cases[3] = '{10, 0, 0, 1, 35};
        cases[4] = '{10, 50, 0, 0, 35};
        cases[5] = '{9, 30, 30, 0, 30};
    endtask

    // case number, row and column, one byte each
    function automatic pixel_pkg::pixel_t pixel_value(input int cn, input int row, input int col);
        return {8'(cn), 8'(row), 8'(col)};
    endfunction

    // rows set..set+3, columns pos-3..pos, left column and top row first
    function automatic pixel_pkg::window_t model_window(input int cn, input int set, input int pos);
        pixel_pkg::window_t w;
        for (int k = 0; k < pixel_pkg::WIN_N; k++) begin
            for (int r = 0; r < pixel_pkg::WIN_N; r++) begin
                w[k][r] = pixel_value(cn, set + r, pos - pixel_pkg::WIN_N + 1 + k);
            end
        end
        return w;
    endfunction

    task automatic build_model(input int cn, input int rows);
        exp_q.delete();
        for (int s = 0; s + pixel_pkg::WIN_N <= rows; s++) begin
            for (int c = pixel_pkg::WIN_N - 1; c < LINE_WIDTH; c++) begin
                exp_q.push_back(model_window(cn, s, c));
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n     <= 1'b0;
        in_valid  <= 1'b0;
        win_ready <= 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (in_ready !== 1'b1) begin
            err_value++;
            $display("ERR in_ready after reset: got %h expected %h", in_ready, 1'b1);
        end
        if (win_valid !== 1'b0) begin
            err_value++;
            $display("ERR win_valid after reset: got %h expected %h", win_valid, 1'b0);
        end
    endtask

    task automatic send_pixels(input int cn, input int rows, input int gap);
        int   total;
        int   idx;
        int   idle;
        logic sent;
        logic waiting;
        total = rows * LINE_WIDTH;
        idx   = 0;
        idle  = 0;
        while (idx < total && idle < WAIT_LIMIT) begin
            @(negedge clk);
            sent    = in_valid & in_ready;
            waiting = in_valid & ~in_ready;
            @(posedge clk);
            if (sent) begin
                idx++;
                idle = 0;
            end else begin
                idle++;
            end
            // a pixel on offer stays until it is taken
            if (!waiting) begin
                if (idx < total && $urandom_range(99) >= gap) begin
                    in_valid <= 1'b1;
                    in_data  <= pixel_value(cn, idx / LINE_WIDTH, idx % LINE_WIDTH);
                end else begin
                    in_valid <= 1'b0;
                end
            end
        end
        if (idx < total) begin
            err_other++;
            $display("timeout: input stream stuck after %0d of %0d pixels", idx, total);
        end
    endtask

    task automatic take_windows(input int cn, input int stall, input int hold, output int got);
        int   idle;
        int   hold_left;
        logic hold_done;
        got       = 0;
        idle      = 0;
        hold_left = 0;
        hold_done = 1'b0;
        while (got < exp_q.size() && idle < WAIT_LIMIT) begin
            @(negedge clk);
            if (win_valid && win_ready) begin
                if (win_data !== exp_q[got]) begin
                    err_value++;
                    $display("ERR win_data case %0d window %0d: got %h expected %h",
                             cn, got, win_data, exp_q[got]);
                end
                got++;
                idle = 0;
            end else begin
                idle++;
            end
            @(posedge clk);
            if (hold != 0 && got >= 1 && !hold_done) begin
                hold_left   = HOLD_CYCLES;
                hold_done   = 1'b1;
                hold_active = 1'b1;
            end
            if (hold_left > 0) begin
                win_ready <= 1'b0;
                hold_left--;
            end else begin
                hold_active = 1'b0;
                win_ready <= ($urandom_range(99) >= stall);
            end
        end
        if (got < exp_q.size()) begin
            err_other++;
            $display("timeout: only %0d of %0d windows arrived in case %0d", got, exp_q.size(), cn);
        end
    endtask

    // in_ready must fall during a long output stall and come back after it
    task automatic watch_stall(input int hold);
        int cnt;
        if (hold != 0) begin
            cnt = 0;
            while (!hold_active && cnt < WAIT_LIMIT) begin
                @(negedge clk);
                cnt++;
            end
            if (!hold_active) begin
                err_other++;
                $display("timeout: the long output stall never started");
            end else begin
                cnt = 0;
                while (in_ready && cnt < 5 * LINE_WIDTH) begin
                    @(negedge clk);
                    cnt++;
                end
                if (in_ready) begin
                    err_other++;
                    $display("in_ready stayed high for five rows of input during the stall");
                end
                cnt = 0;
                while (hold_active && cnt < WAIT_LIMIT) begin
                    @(negedge clk);
                    cnt++;
                end
                cnt = 0;
                while (!in_ready && cnt < 4 * LINE_WIDTH + 8) begin
                    @(negedge clk);
                    cnt++;
                end
                if (!in_ready) begin
                    err_other++;
                    $display("in_ready did not rise again after the output stall ended");
                end
            end
        end
    endtask

    task automatic run_case(input int cn);
        int   got;
        logic extra;
        apply_reset();
        build_model(cn, cases[cn].rows);
        if (exp_q.size() != cases[cn].wins) begin
            err_other++;
            $display("model gives %0d windows but the table expects %0d in case %0d",
                     exp_q.size(), cases[cn].wins, cn);
        end
        hold_active = 1'b0;
        fork
            send_pixels(cn, cases[cn].rows, cases[cn].gap);
            take_windows(cn, cases[cn].stall, cases[cn].hold, got);
            watch_stall(cases[cn].hold);
        join
        if (got != cases[cn].wins) begin
            err_value++;
            $display("ERR window count case %0d: got %h expected %h", cn, got, cases[cn].wins);
        end
        // nothing may follow the last window of the stream
        @(posedge clk);
        win_ready <= 1'b1;
        extra = 1'b0;
        repeat (3 * LINE_WIDTH) begin
            @(negedge clk);
            extra = extra | win_valid;
        end
        if (extra) begin
            err_other++;
            $display("an extra window appeared after the last one in case %0d", cn);
        end
    endtask

    initial begin
        int cn;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        win_ready = 1'b0;
        err_value = 0;
        err_other = 0;
        void'($urandom(SEED));
        load_table();
        for (cn = 0; cn < NUM_CASES; cn++) begin
            run_case(cn);
        end
        $display("errors: %0d wrong values, %0d other failures", err_value, err_other);
        if (err_value == 0 && err_other == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
hdl/pixel_pkg.sv
hdl/geom_pkg.sv
hdl/line_writer.sv
hdl/line_store.sv
hdl/column_reader.sv
hdl/window_shift.sv
hdl/line_window_top.sv
sim/line_window_sva.sv
sim/tb_line_window.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_line_window
FILELIST  = list.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx 'CHECKS FAILED' $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -qx 'ALL CHECKS PASSED' $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
